/* logic/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

	typedef logic [7:0] lcd_byte_t;	// lcd data pins
	typedef logic [8:0] lcd_us_t;	// durations in microseconds
	typedef logic [6:0] lcd_cfg_t;	// {n, f, d, c, b, i_d, s}

	// one word on the lcd bus, rs in the top bit as on the host bus
	typedef struct packed {
		logic rs;
		logic rw;
		lcd_byte_t data;
	} lcd_word_t;

	typedef struct packed {
		lcd_word_t word;
		lcd_us_t hold_us;	// whole bus cycle length
	} lcd_cmd_t;

	// wait after reset before the first command
	localparam lcd_us_t powerup_us = 9'd500;

	// enable pulse shape, shared by every command
	localparam lcd_us_t e_rise_us = 9'd1;
	localparam lcd_us_t e_fall_us = 9'd14;

	localparam lcd_us_t host_hold_us = 9'd50;	// host command cycle

	// init command cycles, pulse plus settle wait
	localparam lcd_us_t init_hold_fs = 9'd60;	// function set
	localparam lcd_us_t init_hold_dc = 9'd60;	// display on/off
	localparam lcd_us_t init_hold_clr = 9'd210;	// clear is slow
	localparam lcd_us_t init_hold_em = 9'd110;	// entry mode

	typedef enum logic [2:0] {
		s_powerup,
		s_init_issue,
		s_init_wait,
		s_ready,
		s_host_wait
	} seq_state_t;

endpackage

`default_nettype wire

/* logic/lcd_bus_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_timing
	import lcd_pkg::*;
#(
	parameter int clk_freq = 1,
	parameter int cnt_bits = 10
) (
	input logic clk,
	input logic reset,
	input lcd_cmd_t cmd,
	input logic cmd_start,
	output logic cmd_done,
	output logic e,
	output logic rs,
	output logic rw,
	output lcd_byte_t lcd_data
);

	localparam int rise_cycles = e_rise_us * clk_freq;
	localparam int fall_cycles = e_fall_us * clk_freq;
	localparam logic [cnt_bits-1:0] rise_cnt = cnt_bits'(rise_cycles);
	localparam logic [cnt_bits-1:0] fall_cnt = cnt_bits'(fall_cycles);

	lcd_cmd_t cmd_q;	// latched command
	logic active;
	logic [cnt_bits-1:0] cnt;	// cycle 0 is the one after cmd_start
	logic [cnt_bits-1:0] last_cnt;
	logic drive;

	assign last_cnt = cnt_bits'(cmd_q.hold_us * clk_freq - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			cnt <= '0;
		end else if (active) begin
			if (cmd_done) begin
				active <= 1'b0;
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end else if (cmd_start) begin
			active <= 1'b1;
			cnt <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!active && cmd_start) begin
			cmd_q <= cmd;
		end
	end

	assign cmd_done = active && (cnt == last_cnt);

	// pins released in the done cycle
	assign drive = active && !cmd_done;
	assign rs = drive && cmd_q.word.rs;
	assign rw = drive && cmd_q.word.rw;
	assign lcd_data = drive ? cmd_q.word.data : '0;

	assign e = active && (cnt >= rise_cnt) && (cnt < fall_cnt);

	// sequencer must wait for cmd_done before the next start
	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		cmd_start |-> !active);

	// e only rises at the fixed offset into a bus cycle
	a_e_in_cycle: assert property (@(posedge clk) disable iff (reset)
		$rose(e) |-> $past(cmd_start, rise_cycles + 1));

endmodule

`default_nettype wire

/* logic/lcd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_sequencer
	import lcd_pkg::*;
#(
	parameter int clk_freq = 1,
	parameter int cnt_bits = 10
) (
	input logic clk,
	input logic reset,
	input lcd_cfg_t init_cfg,
	input lcd_word_t pend_word,
	input logic pend_valid,
	output logic pend_taken,
	output lcd_cmd_t cmd,
	output logic cmd_start,
	input logic cmd_done,
	output logic busy
);

	localparam int host_cycles = host_hold_us * clk_freq;
	localparam logic [cnt_bits-1:0] powerup_last = cnt_bits'(powerup_us * clk_freq - 1);

	seq_state_t state;
	logic [cnt_bits-1:0] cnt;	// power-up delay
	logic [1:0] idx;	// init command index

	// init command table, option bits taken from cfg
	function automatic lcd_cmd_t init_cmd(input logic [1:0] i, input lcd_cfg_t cfg);
		lcd_cmd_t c;
		c.word.rs = 1'b0;
		c.word.rw = 1'b0;
		case (i)
			2'd0: begin
				c.word.data = {4'b0011, cfg[6], cfg[5], 2'b00};	// function set
				c.hold_us = init_hold_fs;
			end
			2'd1: begin
				c.word.data = {5'b00001, cfg[4], cfg[3], cfg[2]};	// display on/off
				c.hold_us = init_hold_dc;
			end
			2'd2: begin
				c.word.data = 8'b00000001;	// clear
				c.hold_us = init_hold_clr;
			end
			default: begin
				c.word.data = {6'b000001, cfg[1], cfg[0]};	// entry mode
				c.hold_us = init_hold_em;
			end
		endcase
		return c;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_powerup;
			cnt <= '0;
			idx <= '0;
		end else begin
			case (state)
				s_powerup: begin
					if (cnt == powerup_last) begin
						cnt <= '0;
						state <= s_init_issue;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				s_init_issue: state <= s_init_wait;
				s_init_wait: begin
					if (cmd_done) begin
						if (idx == 2'd3) begin
							state <= s_ready;
						end else begin
							idx <= idx + 1'b1;
							state <= s_init_issue;
						end
					end
				end
				s_ready: if (pend_valid) state <= s_host_wait;
				s_host_wait: if (cmd_done) state <= s_ready;
				default: state <= s_powerup;
			endcase
		end
	end

	always_comb begin
		if (state == s_init_issue) begin
			cmd = init_cmd(idx, init_cfg);
		end else begin
			cmd.word = pend_word;	// host word, fixed cycle length
			cmd.hold_us = host_hold_us;
		end
	end

	assign cmd_start = (state == s_init_issue) || (state == s_ready && pend_valid);
	assign pend_taken = (state == s_host_wait) && cmd_done;
	assign busy = (state != s_ready);

	// host word finishes exactly one host cycle after its start
	a_taken_timing: assert property (@(posedge clk) disable iff (reset)
		pend_taken |-> $past(cmd_start, host_cycles));

endmodule

`default_nettype wire

/* logic/lcd_host_port.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_host_port
	import lcd_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic host_req,
	input lcd_word_t host_word,
	output logic host_ack,
	output lcd_word_t pend_word,
	output logic pend_valid,
	input logic pend_taken
);

	logic accept;

	// new request, nothing in flight
	assign accept = host_req && !host_ack && !pend_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			pend_valid <= 1'b0;
			host_ack <= 1'b0;
		end else begin
			if (accept) begin
				pend_valid <= 1'b1;
			end
			if (pend_taken) begin
				pend_valid <= 1'b0;
				host_ack <= 1'b1;
			end else if (host_ack && !host_req) begin
				host_ack <= 1'b0;	// req dropped, end of handshake
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pend_word <= host_word;
		end
	end

	// host keeps the word steady until it sees ack
	a_word_stable: assert property (@(posedge clk) disable iff (reset)
		(host_req && !host_ack) ##1 (host_req && !host_ack) |-> $stable(host_word));

endmodule

`default_nettype wire

/* logic/lcd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_top
	import lcd_pkg::*;
#(
	parameter int clk_freq = 1,	// cycles per microsecond
	parameter int cnt_bits = 10	// must hold 500*clk_freq
) (
	input logic clk,
	input logic reset,
	input lcd_cfg_t init_cfg,
	input logic host_req,
	input lcd_word_t host_word,
	output logic host_ack,
	output logic busy,
	output logic e,
	output logic rs,
	output logic rw,
	output lcd_byte_t lcd_data
);

	lcd_word_t pend_word;
	logic pend_valid;
	logic pend_taken;
	lcd_cmd_t cmd;
	logic cmd_start;
	logic cmd_done;

	lcd_host_port u_host (
		.clk(clk),
		.reset(reset),
		.host_req(host_req),
		.host_word(host_word),
		.host_ack(host_ack),
		.pend_word(pend_word),
		.pend_valid(pend_valid),
		.pend_taken(pend_taken)
	);

	lcd_sequencer #(
		.clk_freq(clk_freq),
		.cnt_bits(cnt_bits)
	) u_seq (
		.clk(clk),
		.reset(reset),
		.init_cfg(init_cfg),
		.pend_word(pend_word),
		.pend_valid(pend_valid),
		.pend_taken(pend_taken),
		.cmd(cmd),
		.cmd_start(cmd_start),
		.cmd_done(cmd_done),
		.busy(busy)
	);

	lcd_bus_timing #(
		.clk_freq(clk_freq),
		.cnt_bits(cnt_bits)
	) u_bus (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.cmd_start(cmd_start),
		.cmd_done(cmd_done),
		.e(e),
		.rs(rs),
		.rw(rw),
		.lcd_data(lcd_data)
	);

endmodule

`default_nettype wire

/* bench/tb_lcd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_top
	import lcd_pkg::*;
();

	localparam int clk_freq = 1;
	localparam int cnt_bits = 10;
	localparam int num_words = 6;
	localparam lcd_cfg_t tbl_cfg = 7'b1011110;	// n f d c b i/d s
	localparam int wd_cycles = 2 * (500 + 440 + 60 * num_words) * clk_freq;

	typedef struct packed {
		lcd_word_t word;	// put on the host bus
		logic exp_rs;	// expected pins at the e pulse
		logic exp_rw;
		lcd_byte_t exp_data;
	} host_entry_t;

	host_entry_t tbl [num_words];

	logic clk;
	logic reset;
	lcd_cfg_t init_cfg;
	logic host_req;
	lcd_word_t host_word;
	logic host_ack;
	logic busy;
	logic e;
	logic rs;
	logic rw;
	lcd_byte_t lcd_data;

	int cyc;	// falling edges since time 0
	int rel_cyc;	// cycle of reset release
	int pulse_cnt;
	int rise_cyc;
	int last_host_rise;
	int pin_chg_cyc;
	logic e_d;
	logic [9:0] pins_d;
	logic [9:0] pins_hi;	// pins on the last high sample of e
	logic busy_fell;
	logic [9:0] cap_q [$];	// host pulses in order

	lcd_top #(
		.clk_freq(clk_freq),
		.cnt_bits(cnt_bits)
	) dut (
		.clk(clk),
		.reset(reset),
		.init_cfg(init_cfg),
		.host_req(host_req),
		.host_word(host_word),
		.host_ack(host_ack),
		.busy(busy),
		.e(e),
		.rs(rs),
		.rw(rw),
		.lcd_data(lcd_data)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	// hd44780 init bytes from the option bits
	function automatic lcd_byte_t init_byte(input int idx, input lcd_cfg_t cfg);
		lcd_byte_t b;
		case (idx)
			0: b = {4'b0011, cfg[6:5], 2'b00};
			1: b = {5'b00001, cfg[4:2]};
			2: b = 8'h01;
			default: b = {6'b000001, cfg[1:0]};
		endcase
		return b;
	endfunction

	// pin monitor, samples on the falling clock edge
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (!reset) begin
			if ({rs, rw, lcd_data} != pins_d) pin_chg_cyc = cyc;
			if (!busy) busy_fell = 1'b1;
			check_value(32'(busy || pulse_cnt >= 4), 1, "busy low before init finished");
			if (e && !e_d) begin
				if (pulse_cnt == 0)
					check_value(32'(cyc - rel_cyc >= 500 * clk_freq), 1, "e pulse in power-up wait");
				check_value(32'(cyc - pin_chg_cyc), 32'(clk_freq), "e rise offset from pins");
				if (pulse_cnt >= 5)
					check_value(32'(cyc - last_host_rise >= 50 * clk_freq), 1, "host pulses too close");
				if (pulse_cnt >= 4) last_host_rise = cyc;
				rise_cyc = cyc;
			end
			if (e) pins_hi = {rs, rw, lcd_data};
			if (!e && e_d) begin
				check_value(32'(cyc - rise_cyc), 32'(13 * clk_freq), "e pulse width");
				check_value(32'({rs, rw, lcd_data}), 32'(pins_hi), "pins moved at e fall");
				if (pulse_cnt < 4)
					check_value(32'(pins_hi), 32'({2'b00, init_byte(pulse_cnt, init_cfg)}),
						"init command on pins");
				else
					cap_q.push_back(pins_hi);
				pulse_cnt = pulse_cnt + 1;
			end
		end
		e_d = e;
		pins_d = {rs, rw, lcd_data};
	end

	initial begin
		repeat (wd_cycles + 8) @(posedge clk);
		$display("Watchdog expired, the DUT did not finish the host words in time");
		$display("Regression failed");
		$fatal(1);
	end

	initial begin
		int unsigned gap;
		logic [9:0] got_word;
		void'($urandom(32'ha7cb7e61));
		reset = 1'b1;
		init_cfg = tbl_cfg;
		host_req = 1'b0;
		host_word = '0;
		cyc = 0;
		rel_cyc = 0;
		pulse_cnt = 0;
		rise_cyc = 0;
		last_host_rise = 0;
		pin_chg_cyc = 0;
		e_d = 1'b0;
		pins_d = '0;
		pins_hi = '0;
		busy_fell = 1'b0;
		// host rs, rw, data, then expected rs, rw, data
		tbl[0] = {1'b0, 1'b0, 8'h80, 1'b0, 1'b0, 8'h80};
		tbl[1] = {1'b1, 1'b0, 8'h48, 1'b1, 1'b0, 8'h48};
		tbl[2] = {1'b1, 1'b0, 8'h69, 1'b1, 1'b0, 8'h69};
		tbl[3] = {1'b0, 1'b1, 8'h00, 1'b0, 1'b1, 8'h00};	// read, pattern only
		tbl[4] = {1'b1, 1'b1, 8'ha5, 1'b1, 1'b1, 8'ha5};
		tbl[5] = {1'b0, 1'b0, 8'hc0, 1'b0, 1'b0, 8'hc0};

		repeat (8) @(posedge clk);
		#0.5;
		reset = 1'b0;
		rel_cyc = cyc;
		check_value(32'(busy), 1, "busy after reset");

		// first request lands in the middle of init
		while (pulse_cnt < 2) begin
			@(posedge clk);
			#0.5;
		end
		check_value(32'(busy), 1, "busy during init");

		for (int i = 0; i < num_words; i++) begin
			host_word = tbl[i].word;
			host_req = 1'b1;
			while (!host_ack) begin
				@(posedge clk);
				#0.5;
			end
			if (i == 0) check_value(32'(busy_fell), 1, "first word acked before init finished");
			check_value(32'(pulse_cnt), 32'(5 + i), "e pulse count at ack");
			got_word = cap_q.pop_front();
			check_value(32'(got_word), 32'({tbl[i].exp_rs, tbl[i].exp_rw, tbl[i].exp_data}),
				"host word on pins");
			@(posedge clk);
			#0.5;
			check_value(32'(host_ack), 1, "ack dropped while req high");
			host_req = 1'b0;
			@(posedge clk);
			#0.5;
			check_value(32'(host_ack), 0, "ack still high after req fell");
			gap = $urandom_range(20, 0);
			repeat (gap + 2 * clk_freq) @(posedge clk);
			#0.5;
			check_value(32'(pulse_cnt), 32'(5 + i), "e pulse without a request");
		end

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
logic/lcd_pkg.sv
logic/lcd_bus_timing.sv
logic/lcd_sequencer.sv
logic/lcd_host_port.sv
logic/lcd_top.sv
bench/tb_lcd_top.sv

/* run.sh */
#!/bin/sh
# build the lcd controller testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f sim.f --top-module tb_lcd_top -o tb_lcd_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_lcd_top 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# pass only when the testbench printed its pass line
if echo "$sim_out" | grep -q "^Regression passed$"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
